// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;
    typedef logic [5:0]  opcode;
    typedef logic [5:0]  funct;
    typedef logic [4:0]  shamt;
    typedef logic [2:0]  stepCount;

    typedef enum logic [2:0] {
        stReset, stFetch, stDecode, stExecR, stExecIJ, stOverflow
    } ctrlState;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd} aluOp;
    typedef enum logic [2:0] {shLoad, shLeft, shRightLogic, shRightArith, shHold} shiftOp;
    typedef enum logic {selPc, selRegA} aluASel;
    typedef enum logic [1:0] {selRegB, selFour, selImm, selImmShifted} aluBSel;
    typedef enum logic [1:0] {wbAluOut, wbShift, wbLui} wbSel;
    typedef enum logic [1:0] {pcAlu, pcJump, pcVector} pcSel;

    // primary opcodes
    localparam opcode opR    = 6'b000000;
    localparam opcode opAddi = 6'b001000;
    localparam opcode opLui  = 6'b001111;
    localparam opcode opJ    = 6'b000010;

    // r-type function codes
    localparam funct fnAdd  = 6'b100000;
    localparam funct fnSub  = 6'b100010;
    localparam funct fnAnd  = 6'b100100;
    localparam funct fnSll  = 6'b000000;
    localparam funct fnSrl  = 6'b000010;
    localparam funct fnSra  = 6'b000011;
    localparam funct fnSllv = 6'b000100;
    localparam funct fnSrav = 6'b000111;
    localparam funct fnJr   = 6'b001000;

    // cycles per phase
    localparam stepCount fetchSteps  = 3'd3;
    localparam stepCount decodeSteps = 3'd2;
    localparam stepCount aluSteps    = 3'd2;
    localparam stepCount shiftSteps  = 3'd4;

    localparam word excVector = 32'h0000_0080;

endpackage

`default_nettype wire

// ==== src/aluUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

module aluUnit (
    input  wire cpuPkg::word  a,
    input  wire cpuPkg::word  b,
    input  wire cpuPkg::aluOp fn,
    output cpuPkg::word       result,
    output logic              overflow
);
    import cpuPkg::*;

    word sum;
    word diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (fn)
            aluAdd: begin
                result   = sum;
                // same input signs, different result sign
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            aluSub: begin
                result   = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            default: begin
                result   = a & b;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/shiftUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

module shiftUnit (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire cpuPkg::shiftOp fn,
    input  wire cpuPkg::word    operand,
    input  wire cpuPkg::shamt   amount,
    output cpuPkg::word         result
);
    import cpuPkg::*;

    word  held;
    shamt amt;

    assign result = held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
            amt  <= '0;
        end else begin
            case (fn)
                shLoad: begin
                    held <= operand;
                    amt  <= amount;
                end
                shLeft:       held <= held << amt;
                shRightLogic: held <= held >> amt;
                shRightArith: held <= $signed(held) >>> amt;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none
`timescale 1ns/1ns

module regFile (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire cpuPkg::regAddr raddrA,
    input  wire cpuPkg::regAddr raddrB,
    input  wire cpuPkg::regAddr waddr,
    input  wire logic           we,
    input  wire cpuPkg::word    wdata,
    output cpuPkg::word         rdataA,
    output cpuPkg::word         rdataB
);
    import cpuPkg::*;

    word regs [32];

    // r0 is never written, so it stays at its reset value
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/stepCounter.sv ====
`default_nettype none
`timescale 1ns/1ns

module stepCounter (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             clear,
    input  wire cpuPkg::stepCount phaseLen,
    output cpuPkg::stepCount      step,
    output logic                  lastStep
);
    import cpuPkg::*;

    stepCount lastIdx;

    assign lastIdx  = phaseLen - 3'd1;
    assign lastStep = step == lastIdx;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            step <= '0;
        end else if (!lastStep) begin
            step <= step + 3'd1;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step <= lastIdx);

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

module controlUnit (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire cpuPkg::word    ir,
    input  wire logic           overflow,
    input  wire cpuPkg::stepCount step,
    input  wire logic           lastStep,
    output logic                clear,
    output cpuPkg::stepCount    phaseLen,
    output logic                pcWe,
    output logic                irWe,
    output logic                abWe,
    output logic                aluOutWe,
    output logic                regWe,
    output cpuPkg::aluASel      aluA,
    output cpuPkg::aluBSel      aluB,
    output cpuPkg::aluOp        aluFn,
    output cpuPkg::shiftOp      shFn,
    output logic                shVarAmt,
    output cpuPkg::wbSel        wb,
    output cpuPkg::pcSel        pcSrc,
    output logic                excFlag
);
    import cpuPkg::*;

    ctrlState state;
    ctrlState nextState;
    opcode    op;
    funct     fn;
    logic     aluInstr;
    logic     shiftInstr;
    shiftOp   shiftDir;

    assign op = ir[31:26];
    assign fn = ir[5:0];

    assign aluInstr = (op == opR && (fn == fnAdd || fn == fnSub || fn == fnAnd))
                      || op == opAddi;
    assign shiftInstr = op == opR && (fn == fnSll || fn == fnSrl || fn == fnSra
                                      || fn == fnSllv || fn == fnSrav);

    assign shiftDir = (fn == fnSll || fn == fnSllv) ? shLeft :
                      (fn == fnSrl) ? shRightLogic : shRightArith;

    // every phase ends on its last step
    assign clear = lastStep;

    always_comb begin
        case (state)
            stReset:  nextState = stFetch;
            stFetch:  nextState = stDecode;
            stDecode: nextState = (op == opR) ? stExecR : stExecIJ;
            stExecR, stExecIJ:
                nextState = (aluInstr && overflow) ? stOverflow : stFetch;
            default:  nextState = stFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stReset;
        end else if (lastStep) begin
            state <= nextState;
        end
    end

    always_comb begin
        phaseLen = 3'd1;
        pcWe     = 1'b0;
        irWe     = 1'b0;
        abWe     = 1'b0;
        aluOutWe = 1'b0;
        regWe    = 1'b0;
        aluA     = selPc;
        aluB     = selFour;
        aluFn    = aluAdd;
        shFn     = shHold;
        shVarAmt = 1'b0;
        wb       = wbAluOut;
        pcSrc    = pcAlu;
        excFlag  = 1'b0;
        case (state)
            stFetch: begin
                phaseLen = fetchSteps;
                // pc + 4 and the instruction land together
                pcWe = lastStep;
                irWe = lastStep;
            end
            stDecode: begin
                phaseLen = decodeSteps;
                abWe = 1'b1;
            end
            stExecR: begin
                aluA = selRegA;
                aluB = selRegB;
                if (aluInstr) begin
                    phaseLen = aluSteps;
                    aluFn    = (fn == fnSub) ? aluSub : (fn == fnAnd) ? aluAnd : aluAdd;
                    aluOutWe = step == 3'd0;
                    regWe    = lastStep && !overflow;
                end else if (shiftInstr) begin
                    phaseLen = shiftSteps;
                    shVarAmt = fn == fnSllv || fn == fnSrav;
                    wb       = wbShift;
                    if (step < 3'd2) begin
                        shFn = shLoad;
                    end else if (step == 3'd2) begin
                        shFn = shiftDir;
                    end
                    regWe = lastStep;
                end else if (fn == fnJr) begin
                    // rt is zero in jr, so A + B is rs
                    pcWe = 1'b1;
                end
            end
            stExecIJ: begin
                if (op == opAddi) begin
                    phaseLen = aluSteps;
                    aluA     = selRegA;
                    aluB     = selImm;
                    aluOutWe = step == 3'd0;
                    regWe    = lastStep && !overflow;
                end else if (op == opLui) begin
                    wb    = wbLui;
                    regWe = 1'b1;
                end else if (op == opJ) begin
                    pcSrc = pcJump;
                    pcWe  = 1'b1;
                end
            end
            stOverflow: begin
                pcSrc   = pcVector;
                pcWe    = 1'b1;
                excFlag = 1'b1;
            end
            default: ;
        endcase
    end

    noWriteOnException: assert property (@(posedge clk) disable iff (reset)
        !(regWe && pcSrc == pcVector));

    irOnlyInFetch: assert property (@(posedge clk) disable iff (reset)
        irWe |-> state == stFetch);

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`default_nettype none
`timescale 1ns/1ns

module datapath (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire cpuPkg::word    instrData,
    input  wire logic           pcWe,
    input  wire logic           irWe,
    input  wire logic           abWe,
    input  wire logic           aluOutWe,
    input  wire logic           regWe,
    input  wire cpuPkg::aluASel aluA,
    input  wire cpuPkg::aluBSel aluB,
    input  wire cpuPkg::aluOp   aluFn,
    input  wire cpuPkg::shiftOp shFn,
    input  wire logic           shVarAmt,
    input  wire cpuPkg::wbSel   wb,
    input  wire cpuPkg::pcSel   pcSrc,
    output cpuPkg::word         ir,
    output cpuPkg::word         instrAddr,
    output logic                overflow,
    output cpuPkg::regAddr      regWaddr,
    output cpuPkg::word         regWdata
);
    import cpuPkg::*;

    word  pc, regA, regB, aluOut;
    word  rdataA, rdataB, opA, opB, aluResult, shResult, immExt, pcNext;
    logic aluOvf;
    shamt shAmount;

    assign instrAddr = pc;
    assign immExt    = {{16{ir[15]}}, ir[15:0]};
    assign regWaddr  = (ir[31:26] == opR) ? ir[15:11] : ir[20:16];
    // variable amount comes from rs
    assign shAmount  = shVarAmt ? regA[4:0] : ir[10:6];

    always_comb begin
        opA = (aluA == selRegA) ? regA : pc;
        case (aluB)
            selRegB:       opB = regB;
            selFour:       opB = 32'd4;
            default:       opB = immExt;
        endcase
        case (wb)
            wbShift: regWdata = shResult;
            wbLui:   regWdata = {ir[15:0], 16'h0000};
            default: regWdata = aluOut;
        endcase
        case (pcSrc)
            pcJump:   pcNext = {pc[31:28], ir[25:0], 2'b00};
            pcVector: pcNext = excVector;
            default:  pcNext = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            ir       <= '0;
            overflow <= 1'b0;
        end else begin
            if (pcWe) pc <= pcNext;
            if (irWe) ir <= instrData;
            if (aluOutWe) overflow <= aluOvf;
        end
    end

    always_ff @(posedge clk) begin
        if (abWe) begin
            regA <= rdataA;
            regB <= rdataB;
        end
        if (aluOutWe) aluOut <= aluResult;
    end

    regFile regs (.clk(clk), .reset(reset), .raddrA(ir[25:21]), .raddrB(ir[20:16]),
                  .waddr(regWaddr), .we(regWe), .wdata(regWdata),
                  .rdataA(rdataA), .rdataB(rdataB));

    aluUnit alu (.a(opA), .b(opB), .fn(aluFn), .result(aluResult), .overflow(aluOvf));

    shiftUnit shifter (.clk(clk), .reset(reset), .fn(shFn), .operand(regB),
                       .amount(shAmount), .result(shResult));

endmodule

`default_nettype wire

// ==== src/miniMipsCore.sv ====
`default_nettype none
`timescale 1ns/1ns

module miniMipsCore (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire cpuPkg::word instrData,
    output cpuPkg::word      instrAddr,
    output cpuPkg::word      pc,
    output logic             regWe,
    output cpuPkg::regAddr   regWaddr,
    output cpuPkg::word      regWdata,
    output logic             excFlag
);
    import cpuPkg::*;

    word      ir;
    logic     overflow, clear, lastStep;
    stepCount step, phaseLen;
    logic     pcWe, irWe, abWe, aluOutWe, shVarAmt;
    aluASel   aluA;
    aluBSel   aluB;
    aluOp     aluFn;
    shiftOp   shFn;
    wbSel     wb;
    pcSel     pcSrc;

    assign pc = instrAddr;

    controlUnit ctrl (.clk(clk), .reset(reset), .ir(ir), .overflow(overflow), .step(step),
                      .lastStep(lastStep), .clear(clear), .phaseLen(phaseLen), .pcWe(pcWe),
                      .irWe(irWe), .abWe(abWe), .aluOutWe(aluOutWe), .regWe(regWe),
                      .aluA(aluA), .aluB(aluB), .aluFn(aluFn), .shFn(shFn),
                      .shVarAmt(shVarAmt), .wb(wb), .pcSrc(pcSrc), .excFlag(excFlag));

    stepCounter steps (.clk(clk), .reset(reset), .clear(clear), .phaseLen(phaseLen),
                       .step(step), .lastStep(lastStep));

    datapath dp (.clk(clk), .reset(reset), .instrData(instrData), .pcWe(pcWe), .irWe(irWe),
                 .abWe(abWe), .aluOutWe(aluOutWe), .regWe(regWe), .aluA(aluA), .aluB(aluB),
                 .aluFn(aluFn), .shFn(shFn), .shVarAmt(shVarAmt), .wb(wb), .pcSrc(pcSrc),
                 .ir(ir), .instrAddr(instrAddr), .overflow(overflow),
                 .regWaddr(regWaddr), .regWdata(regWdata));

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
`default_nettype none
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic reset
);
    localparam int halfPeriod  = 50;
    localparam int resetCycles = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // held over the first 16 rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/coreTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module coreTb;
    import cpuPkg::*;

    localparam int  maxRows      = 64;
    localparam int  rowWords     = 5;
    localparam int  resetCycles  = 16;
    localparam int  cyclesPerRow = 12;
    // row kinds in the stimulus file
    localparam word kindEnd      = 32'd0;
    localparam word kindWrite    = 32'd1;
    localparam word kindJump     = 32'd2;
    localparam word kindExc      = 32'd3;
    localparam word jumpToZero   = 32'h0800_0000;

    logic   clk;
    logic   reset;
    word    instrData;
    word    instrAddr;
    word    pc;
    logic   regWe;
    regAddr regWaddr;
    word    regWdata;
    logic   excFlag;

    word stim [maxRows * rowWords];
    int  entryCount;

    clockGen clocks (.clk(clk), .reset(reset));

    miniMipsCore UUT (.clk(clk), .reset(reset), .instrData(instrData), .instrAddr(instrAddr),
                      .pc(pc), .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
                      .excFlag(excFlag));

    task automatic failRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input word expected, input word actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkRegAddr(input string name, input regAddr expected, input regAddr actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
        end
    endtask

    function automatic int findRow(input word addr);
        int found;
        found = -1;
        for (int r = 0; r < entryCount; r++) begin
            if (stim[r * rowWords] == addr) begin
                found = r;
            end
        end
        return found;
    endfunction

    // unlisted addresses read as j 0
    function automatic word instrAt(input word addr);
        int r;
        r = findRow(addr);
        if (r < 0) begin
            return jumpToZero;
        end
        return stim[r * rowWords + 1];
    endfunction

    always @(negedge clk) begin
        instrData = instrAt(instrAddr);
    end

    task automatic waitActivity();
        @(negedge clk);
        while (!(regWe || excFlag)) begin
            @(negedge clk);
        end
    endtask

    // pc passes through pc + 4 before the jump overwrites it
    task automatic waitJump(input word fallThrough);
        @(negedge clk);
        while (pc !== fallThrough) begin
            @(negedge clk);
        end
        @(negedge clk);
        while (pc === fallThrough && !regWe && !excFlag) begin
            @(negedge clk);
        end
    endtask

    task automatic checkRow(input int r, output word nextAddr);
        word   addr;
        word   kind;
        word   arg1;
        word   arg2;
        string tag;
        addr     = stim[r * rowWords];
        kind     = stim[r * rowWords + 2];
        arg1     = stim[r * rowWords + 3];
        arg2     = stim[r * rowWords + 4];
        tag      = $sformatf("instr %h at %h", stim[r * rowWords + 1], addr);
        nextAddr = addr + 32'd4;
        case (kind)
            kindWrite: begin
                waitActivity();
                checkFlag({tag, " excFlag"}, 1'b0, excFlag);
                checkRegAddr({tag, " regWaddr"}, arg1[4:0], regWaddr);
                checkWord({tag, " regWdata"}, arg2, regWdata);
                checkWord({tag, " pc"}, addr + 32'd4, pc);
                checkWord({tag, " instrAddr"}, addr + 32'd4, instrAddr);
            end
            kindJump: begin
                waitJump(addr + 32'd4);
                checkFlag({tag, " regWe"}, 1'b0, regWe);
                checkFlag({tag, " excFlag"}, 1'b0, excFlag);
                checkWord({tag, " pc"}, arg1, pc);
                checkWord({tag, " instrAddr"}, arg1, instrAddr);
                nextAddr = arg1;
            end
            kindExc: begin
                waitActivity();
                checkFlag({tag, " regWe"}, 1'b0, regWe);
                checkFlag({tag, " excFlag"}, 1'b1, excFlag);
                // vector is in pc once the exception cycle is over
                @(negedge clk);
                checkWord({tag, " pc"}, arg1, pc);
                nextAddr = arg1;
            end
            default: begin
                failRun($sformatf("stimulus row %0d has an unknown kind %0d", r, kind));
            end
        endcase
    endtask

    initial begin
        int  r;
        word cur;
        instrData  = '0;
        entryCount = 0;
        $readmemh("verif/coreStimulus.txt", stim);
        while (entryCount < maxRows && stim[entryCount * rowWords + 2] != kindEnd) begin
            entryCount++;
        end
        if (entryCount == 0) begin
            failRun("the stimulus file holds no rows");
        end
        @(negedge reset);
        cur = '0;
        // follow the program flow, one row per executed instruction
        for (int n = 0; n < entryCount; n++) begin
            r = findRow(cur);
            if (r < 0) begin
                failRun($sformatf("program reached %h, which has no stimulus row", cur));
            end else begin
                checkRow(r, cur);
            end
        end
        $display("** PASS **");
        $finish;
    end

    initial begin
        int limit;
        @(posedge clk);
        limit = entryCount * cyclesPerRow + resetCycles;
        repeat (limit) @(posedge clk);
        failRun($sformatf("timeout: program did not finish within %0d cycles", limit + 1));
    end

endmodule

`default_nettype wire

// ==== verif/coreStimulus.txt ====
// columns: byte address, instruction, kind, arg1, arg2
// kind 1 write (arg1 reg, arg2 data), 2 jump (arg1 pc), 3 overflow (arg1 vector), 0 end
00000000 2002FFFF 1 00000002 FFFFFFFF
00000004 3C03F0F0 1 00000003 F0F00000
00000008 20640F0F 1 00000004 F0F00F0F
0000000C 20050005 1 00000005 00000005
00000010 00853020 1 00000006 F0F00F14
00000014 00823822 1 00000007 F0F00F10
00000018 00864024 1 00000008 F0F00F04
0000001C 00044900 1 00000009 0F00F0F0
00000020 00035202 1 0000000A 00F0F000
00000024 00035A03 1 0000000B FFF0F000
00000028 00A46004 1 0000000C 1E01E1E0
0000002C 00A36807 1 0000000D FF878000
00000030 20001234 1 00000000 00001234
00000034 00057020 1 0000000E 00000005
00000038 08000010 2 00000040 00000000
0000003C 08000012 2 00000048 00000000
00000040 200F003C 1 0000000F 0000003C
00000044 01E00008 2 0000003C 00000000
00000048 00020842 1 00000001 7FFFFFFF
0000004C 20100001 1 00000010 00000001
00000050 00308820 3 00000080 00000000
00000080 20320001 3 00000080 00000000
00000000 00000000 0 00000000 00000000

// ==== project.f ====
src/cpuPkg.sv
src/aluUnit.sv
src/shiftUnit.sv
src/regFile.sv
src/stepCounter.sv
src/controlUnit.sv
src/datapath.sv
src/miniMipsCore.sv
verif/clockGen.sv
verif/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
